// File: Bender.yml
package:
  name: cpu_core

sources:
  - files:
      - common/cpuPkg.sv
      - alu/alu.sv
      - src/progMem.sv
      - src/pcCounter.sv
      - src/sequencer.sv
      - src/regFile.sv
      - src/cpuTop.sv
  - target: simulation
    files:
      - bench/cpuTb.sv

// File: alu/alu.sv
// sixteen-operation ALU with registered carry, zero and sign flags, driven by the sequencer
module alu #(
	parameter int BITS = cpuPkg::dataWidth
) (
	input logic CLK,
	input logic RSTb,
	input logic [BITS-1:0] A, // destination register value
	input logic [BITS-1:0] B, // source register or immediate
	input cpuPkg::aluOpT aluOp,
	input logic aluEn, // flags only move when set
	output logic [BITS-1:0] aluOut,
	output logic C,
	output logic Z,
	output logic S
);
	import cpuPkg::*;

	logic cFlag, cNext;
	logic zFlag, zNext;
	logic sFlag, sNext;
	logic [BITS:0] addRes;
	logic [BITS:0] subRes;
	logic [BITS-1:0] andRes;
	logic [BITS-1:0] orRes;
	logic [BITS-1:0] xorRes;

	assign C = cFlag;
	assign Z = zFlag;
	assign S = sFlag;

	assign addRes = {1'b0, A} + {1'b0, B};
	assign subRes = {1'b0, A} - {1'b0, B}; // top bit is the borrow
	assign andRes = A & B;
	assign orRes = A | B;
	assign xorRes = A ^ B;

	always_comb begin
		cNext = cFlag; // flags hold unless the op touches them
		zNext = zFlag;
		sNext = sFlag;
		aluOut = '0;
		case (aluOp)
			aluMove: aluOut = B;
			aluClrC: cNext = 1'b0;
			aluSetC: cNext = 1'b1;
			aluClrZ: zNext = 1'b0;
			aluSetZ: zNext = 1'b1;
			aluClrS: sNext = 1'b0;
			aluSetS: sNext = 1'b1;
			aluAdd: begin
				aluOut = addRes[BITS-1:0];
				cNext = addRes[BITS];
				zNext = (addRes[BITS-1:0] == '0);
				sNext = addRes[BITS-1];
			end
			aluSub: begin
				aluOut = subRes[BITS-1:0];
				cNext = subRes[BITS];
				zNext = (subRes[BITS-1:0] == '0);
				sNext = subRes[BITS-1];
			end
			aluAsr: aluOut = {A[BITS-1], A[BITS-1:1]}; // sign kept
			aluLsl: aluOut = {A[BITS-2:0], 1'b0};
			aluAnd: begin
				aluOut = andRes;
				zNext = (andRes == '0);
			end
			aluOr: begin
				aluOut = orRes;
				zNext = (orRes == '0);
			end
			aluXor: begin
				aluOut = xorRes;
				zNext = (xorRes == '0);
			end
			aluRol: begin
				// rotate through carry
				aluOut = {A[BITS-2:0], cFlag};
				cNext = A[BITS-1];
			end
			aluRor: begin
				aluOut = {cFlag, A[BITS-1:1]};
				cNext = A[0];
			end
			default: aluOut = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			cFlag <= 1'b0;
			zFlag <= 1'b0;
			sFlag <= 1'b0;
		end else if (aluEn) begin
			cFlag <= cNext;
			zFlag <= zNext;
			sFlag <= sNext;
		end
	end

	// a half-decoded instruction would corrupt the flags
	aluOpKnown: assert property (@(posedge CLK) disable iff (!RSTb)
		aluEn |-> !$isunknown(aluOp));

endmodule

// File: bench/cpuTb.sv
// self-checking testbench for cpuTop, loads small programs and compares write-backs with an ISS model
module cpuTb;
	timeunit 1ns;
	timeprecision 1ps;
	import cpuPkg::*;

	logic CLK;
	logic RSTb;
	logic progWrite;
	pcT progAddr;
	instrT progData;
	logic start;
	logic wbStrobe;
	regAddrT wbReg;
	wordT wbData;
	logic halted;
	logic C;
	logic Z;
	logic S;

	int cycles = 0;
	int budget = 200; // grows by 4 cycles per modeled instruction
	instrT prog [256]; // mirror of program memory
	instrT code[$]; // program under construction
	wordT mRegs [16];
	logic mC, mZ, mS; // model flags
	regAddrT expReg[$];
	wordT expData[$];
	regAddrT gotReg[$];
	wordT gotData[$];
	aluOpT tOp[$]; // ALU table columns
	wordT tA[$], tB[$], tRes[$];
	logic tCin[$], tCout[$];

	cpuTop #(.BITS(dataWidth)) cpuTop_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.start(start),
		.wbStrobe(wbStrobe),
		.wbReg(wbReg),
		.wbData(wbData),
		.halted(halted),
		.C(C),
		.Z(Z),
		.S(S)
	);

	always #20 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles++;
		if (cycles > budget) begin
			$display("timeout: core did not halt within %0d cycles", budget);
			$display("TESTBENCH FAILED");
			$fatal(1, "cycle limit reached");
		end
	end

	function automatic instrT encAlu(aluOpT op, regAddrT rd, regAddrT rs);
		return {majAlu, rd, rs, op};
	endfunction

	function automatic instrT encLdi(regAddrT rd, immT v);
		return {majLdi, rd, v};
	endfunction

	function automatic instrT encBr(logic [3:0] cond, pcT target);
		return {majBranch, cond, target};
	endfunction

	function automatic instrT encHalt();
		return {majHalt, 12'h000};
	endfunction

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkWord(input wordT got, input wordT exp, input string what);
		if (got !== exp) begin
			abortRun($sformatf("ERR @ %0d ns: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			abortRun($sformatf("ERR @ %0d ns: %s is %b, expected %b", $time, what, got, exp));
		end
	endtask

	task automatic checkReg(input regAddrT got, input regAddrT exp, input string what);
		if (got !== exp) begin
			abortRun($sformatf("ERR @ %0d ns: %s is r%0d, expected r%0d", $time, what, got, exp));
		end
	endtask

	task automatic checkCount(input int got, input int exp, input string what);
		if (got != exp) begin
			abortRun($sformatf("ERR @ %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
		end
	endtask

	// reference ALU, flags follow the instruction set rules
	task automatic modelAlu(input aluOpT op, input wordT a, input wordT b,
			output wordT res, output bit writes);
		logic [$bits(wordT):0] wide;
		res = '0;
		writes = (op == aluMove) || (op > aluSetS);
		case (op)
			aluMove: res = b;
			aluClrC: mC = 1'b0;
			aluSetC: mC = 1'b1;
			aluClrZ: mZ = 1'b0;
			aluSetZ: mZ = 1'b1;
			aluClrS: mS = 1'b0;
			aluSetS: mS = 1'b1;
			aluAdd: begin
				wide = a + b;
				res = wordT'(wide);
				mC = wide[$bits(wordT)];
			end
			aluSub: begin
				res = a - b;
				mC = (a < b); // borrow
			end
			aluAsr: res = $signed(a) >>> 1;
			aluLsl: res = a << 1;
			aluAnd: res = a & b;
			aluOr: res = a | b;
			aluXor: res = a ^ b;
			aluRol: {mC, res} = {a, mC}; // 17-bit rotate through carry
			aluRor: {res, mC} = {mC, a};
			default: res = '0;
		endcase
		if (op inside {aluAdd, aluSub}) begin
			mS = res[$bits(wordT)-1];
		end
		if (op inside {aluAdd, aluSub, aluAnd, aluOr, aluXor}) begin
			mZ = (res == '0);
		end
	endtask

	// instruction-level model, state carries over between programs like the core's
	task automatic modelRun(output int steps);
		pcT pc;
		instrT w;
		wordT res;
		bit writes;
		bit done;
		bit taken;
		pc = '0;
		steps = 0;
		done = 1'b0;
		expReg.delete();
		expData.delete();
		while (!done) begin
			w = prog[pc];
			steps++;
			if (steps > 1000) begin
				abortRun("model ran 1000 instructions without reaching a halt");
			end
			pc = pc + 1'b1;
			case (w[15:12])
				4'h0: begin
					modelAlu(aluOpT'(w[3:0]), mRegs[w[11:8]], mRegs[w[7:4]], res, writes);
					if (writes) begin
						mRegs[w[11:8]] = res;
						expReg.push_back(w[11:8]);
						expData.push_back(res);
					end
				end
				4'h1: begin
					mRegs[w[11:8]] = wordT'(w[7:0]); // zero-extended
					expReg.push_back(w[11:8]);
					expData.push_back(wordT'(w[7:0]));
				end
				4'h2: begin
					case (w[11:8])
						4'd0: taken = 1'b1;
						4'd1: taken = mC;
						4'd2: taken = mZ;
						4'd3: taken = mS;
						4'd4: taken = !mZ;
						default: taken = 1'b0;
					endcase
					if (taken) begin
						pc = w[7:0];
					end
				end
				4'h3: done = 1'b1;
				default: ; // no-op
			endcase
		end
	endtask

	// load code[], start, gather write-backs until halted, compare with the model
	task automatic runProgram();
		int steps;
		foreach (code[i]) prog[i] = code[i];
		modelRun(steps);
		budget += 4 * steps;
		foreach (code[i]) begin
			@(negedge CLK);
			progWrite = 1'b1;
			progAddr = pcT'(i);
			progData = code[i];
		end
		@(negedge CLK);
		progWrite = 1'b0;
		start = 1'b1;
		@(negedge CLK);
		start = 1'b0;
		gotReg.delete();
		gotData.delete();
		while (!halted) begin
			if (wbStrobe) begin
				gotReg.push_back(wbReg);
				gotData.push_back(wbData);
			end
			@(negedge CLK);
		end
		checkCount(gotReg.size(), expReg.size(), "write-back count");
		foreach (gotReg[i]) begin
			checkReg(gotReg[i], expReg[i], $sformatf("write-back %0d register", i));
			checkWord(gotData[i], expData[i], $sformatf("write-back %0d data", i));
		end
		checkFlag(C, mC, "C flag");
		checkFlag(Z, mZ, "Z flag");
		checkFlag(S, mS, "S flag");
	endtask

	task automatic emitOperand(input regAddrT rd, input wordT v);
		code.push_back(encLdi(rd, v[15:8]));
		repeat (8) code.push_back(encAlu(aluLsl, rd, rd));
		code.push_back(encLdi(4'd3, v[7:0])); // r3 is scratch
		code.push_back(encAlu(aluOr, rd, 4'd3));
	endtask

	task automatic runAluCase(input aluOpT op, input wordT a, input wordT b, input logic cIn);
		code.delete();
		emitOperand(4'd1, a);
		emitOperand(4'd2, b);
		code.push_back(encAlu(cIn ? aluSetC : aluClrC, 4'd0, 4'd0));
		code.push_back(encAlu(op, 4'd1, 4'd2));
		code.push_back(encHalt());
		runProgram();
	endtask

	task automatic addCase(input aluOpT op, input wordT a, input wordT b, input logic cIn,
			input wordT res, input logic cOut);
		tOp.push_back(op);
		tA.push_back(a);
		tB.push_back(b);
		tCin.push_back(cIn);
		tRes.push_back(res); // last write-back, the B build for flag ops
		tCout.push_back(cOut);
	endtask

	task automatic fillTable();
		addCase(aluMove, 16'h1234, 16'hABCD, 1'b0, 16'hABCD, 1'b0);
		addCase(aluClrC, 16'h0001, 16'h0002, 1'b1, 16'h0002, 1'b0);
		addCase(aluSetC, 16'h0003, 16'h0004, 1'b0, 16'h0004, 1'b1);
		addCase(aluClrZ, 16'h0005, 16'h0006, 1'b0, 16'h0006, 1'b0);
		addCase(aluSetZ, 16'h0007, 16'h0008, 1'b1, 16'h0008, 1'b1);
		addCase(aluClrS, 16'h0009, 16'h000A, 1'b0, 16'h000A, 1'b0);
		addCase(aluSetS, 16'h000B, 16'h000C, 1'b1, 16'h000C, 1'b1);
		addCase(aluAdd, 16'hFFFF, 16'h0001, 1'b0, 16'h0000, 1'b1); // overflow
		addCase(aluAdd, 16'h7FFF, 16'h0001, 1'b1, 16'h8000, 1'b0);
		addCase(aluSub, 16'h0005, 16'h0007, 1'b0, 16'hFFFE, 1'b1); // borrow
		addCase(aluSub, 16'h9000, 16'h1000, 1'b1, 16'h8000, 1'b0);
		addCase(aluAsr, 16'h8004, 16'h0000, 1'b0, 16'hC002, 1'b0);
		addCase(aluLsl, 16'hC001, 16'h0000, 1'b1, 16'h8002, 1'b1);
		addCase(aluAnd, 16'hF0F0, 16'h0F0F, 1'b0, 16'h0000, 1'b0);
		addCase(aluOr, 16'h1200, 16'h0034, 1'b1, 16'h1234, 1'b1);
		addCase(aluXor, 16'hAAAA, 16'hAAAA, 1'b0, 16'h0000, 1'b0);
		addCase(aluRol, 16'h8001, 16'h0000, 1'b1, 16'h0003, 1'b1);
		addCase(aluRor, 16'h0001, 16'h0000, 1'b0, 16'h0000, 1'b1);
		addCase(aluRor, 16'h8000, 16'h0000, 1'b1, 16'hC000, 1'b0);
	endtask

	initial begin
		aluOpT op;
		wordT ra;
		wordT rb;
		logic prevC, prevZ, prevS;
		int changed;
		CLK = 1'b0;
		RSTb = 1'b0;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		start = 1'b0;
		{mC, mZ, mS} = 3'b000;
		foreach (mRegs[i]) mRegs[i] = '0;
		void'($urandom(25));
		fillTable();
		repeat (2) @(negedge CLK);
		RSTb = 1'b1;

		// reset state, then a lone halt
		@(negedge CLK);
		checkFlag(wbStrobe, 1'b0, "wbStrobe after reset");
		checkFlag(halted, 1'b0, "halted after reset");
		checkFlag(C, 1'b0, "C after reset");
		checkFlag(Z, 1'b0, "Z after reset");
		checkFlag(S, 1'b0, "S after reset");
		code.delete();
		code.push_back(encHalt());
		runProgram();
		checkCount(gotReg.size(), 0, "write-backs of halt-only program");

		foreach (tOp[i]) begin
			runAluCase(tOp[i], tA[i], tB[i], tCin[i]);
			checkReg(gotReg[gotReg.size()-1], (tOp[i] inside {[aluClrC:aluSetS]}) ? 4'd2 : 4'd1,
				$sformatf("%s last register", tOp[i].name()));
			checkWord(gotData[gotData.size()-1], tRes[i], $sformatf("%s result", tOp[i].name()));
			checkFlag(C, tCout[i], $sformatf("%s carry", tOp[i].name()));
		end

		// flag-only ops from all clear: setC setZ setS clrC clrZ clrS
		code.delete();
		code.push_back(encAlu(aluClrC, 4'd0, 4'd0));
		code.push_back(encAlu(aluClrZ, 4'd0, 4'd0));
		code.push_back(encAlu(aluClrS, 4'd0, 4'd0));
		code.push_back(encHalt());
		runProgram();
		for (int k = 0; k < 6; k++) begin
			op = aluOpT'((k < 3) ? 2 + 2 * k : 1 + 2 * (k - 3));
			{prevC, prevZ, prevS} = {C, Z, S};
			code.delete();
			code.push_back(encAlu(op, 4'd4, 4'd4));
			code.push_back(encHalt());
			runProgram();
			checkCount(gotReg.size(), 0, $sformatf("%s write-backs", op.name()));
			changed = (C !== prevC) + (Z !== prevZ) + (S !== prevS);
			checkCount(changed, 1, $sformatf("flags changed by %s", op.name()));
		end

		// countdown from 6
		code.delete();
		code.push_back(encLdi(4'd5, 8'd6));
		code.push_back(encLdi(4'd6, 8'd1));
		code.push_back(encAlu(aluSub, 4'd5, 4'd6)); // loop head at 2
		code.push_back(encBr(brNotZero, 8'd2));
		code.push_back(encHalt());
		runProgram();
		checkCount(gotReg.size(), 8, "countdown write-backs");
		checkWord(gotData[gotData.size()-1], '0, "countdown end value");
		checkFlag(Z, 1'b1, "Z after countdown");

		// none of these branches may be taken
		code.delete();
		code.push_back(encAlu(aluClrC, 4'd0, 4'd0));
		code.push_back(encAlu(aluClrZ, 4'd0, 4'd0));
		code.push_back(encAlu(aluClrS, 4'd0, 4'd0));
		code.push_back(encBr(brCarry, 8'd10));
		code.push_back(encBr(brZero, 8'd10));
		code.push_back(encBr(brSign, 8'd10));
		code.push_back(encBr(4'd5, 8'd10));
		code.push_back(encBr(4'd15, 8'd10));
		code.push_back(encLdi(4'd8, 8'h5A));
		code.push_back(encHalt());
		code.push_back(encLdi(4'd8, 8'hEE)); // reached only by a wrong branch
		code.push_back(encHalt());
		runProgram();
		checkCount(gotReg.size(), 1, "fall-through write-backs");
		checkWord(gotData[0], 16'h005A, "fall-through value");

		for (int i = 0; i < 20; i++) begin
			case ($urandom % 3)
				0: op = aluAdd;
				1: op = aluSub;
				default: op = aluXor;
			endcase
			ra = wordT'($urandom);
			rb = wordT'($urandom);
			runAluCase(op, ra, rb, 1'($urandom));
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: common/cpuPkg.sv
// shared widths, instruction fields and encodings for the accumulator core, imported by each block
package cpuPkg;

	localparam int dataWidth = 16; // default register and ALU width

	typedef logic [dataWidth-1:0] wordT;
	typedef logic [15:0] instrT; // major[15:12] rd/cond[11:8] rs[7:4] op[3:0]
	typedef logic [7:0] pcT; // 256 program words
	typedef logic [3:0] regAddrT;
	typedef logic [7:0] immT; // low byte of immediate and branch words

	typedef enum logic [3:0] {
		aluMove, aluClrC, aluSetC, aluClrZ, aluSetZ, aluClrS, aluSetS, aluAdd,
		aluSub, aluAsr, aluLsl, aluAnd, aluOr, aluXor, aluRol, aluRor
	} aluOpT;

	// values 4..15 decode as no-op
	typedef enum logic [3:0] {majAlu, majLdi, majBranch, majHalt} majorOpT;

	// anything above brNotZero is never taken
	typedef enum logic [3:0] {brAlways, brCarry, brZero, brSign, brNotZero} branchCondT;

	typedef enum logic [1:0] {IDLE, FETCH, EXEC, HALT} seqStateT;

	function automatic majorOpT getMajor(instrT i);
		return majorOpT'(i[15:12]);
	endfunction

	function automatic regAddrT getRd(instrT i);
		return i[11:8];
	endfunction

	function automatic branchCondT getCond(instrT i);
		return branchCondT'(i[11:8]); // shares the rd field
	endfunction

	function automatic regAddrT getRs(instrT i);
		return i[7:4];
	endfunction

	function automatic aluOpT getAluOp(instrT i);
		return aluOpT'(i[3:0]);
	endfunction

	function automatic immT getImm(instrT i);
		return i[7:0];
	endfunction

endpackage

// File: src/cpuTop.sv
// core top level, host loads the program, pulses start and watches the write-back port
module cpuTop #(
	parameter int BITS = cpuPkg::dataWidth
) (
	input logic CLK,
	input logic RSTb,
	input logic progWrite,
	input cpuPkg::pcT progAddr,
	input cpuPkg::instrT progData,
	input logic start,
	output logic wbStrobe,
	output cpuPkg::regAddrT wbReg,
	output logic [BITS-1:0] wbData,
	output logic halted,
	output logic C,
	output logic Z,
	output logic S
);
	import cpuPkg::*;

	pcT pc;
	pcT pcTarget;
	instrT instr;
	regAddrT rdAddr;
	regAddrT rsAddr;
	immT imm;
	aluOpT aluOp;
	logic useImm;
	logic aluEn;
	logic regWrite;
	logic pcClear;
	logic pcInc;
	logic pcLoad;
	logic running;
	logic progWe;
	logic [BITS-1:0] opA;
	logic [BITS-1:0] opB;
	logic [BITS-1:0] aluOut;

	assign progWe = progWrite && !running; // host loads only when stopped
	assign wbReg = rdAddr;
	assign wbData = aluOut;

	progMem progMem_i (
		.CLK(CLK),
		.progWrite(progWe),
		.progAddr(progAddr),
		.progData(progData),
		.pc(pc),
		.instr(instr)
	);

	pcCounter pcCounter_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.pcClear(pcClear),
		.pcInc(pcInc),
		.pcLoad(pcLoad),
		.pcTarget(pcTarget),
		.pc(pc)
	);

	sequencer sequencer_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.start(start),
		.instr(instr),
		.C(C),
		.Z(Z),
		.S(S),
		.rdAddr(rdAddr),
		.rsAddr(rsAddr),
		.useImm(useImm),
		.imm(imm),
		.aluOp(aluOp),
		.aluEn(aluEn),
		.regWrite(regWrite),
		.pcClear(pcClear),
		.pcInc(pcInc),
		.pcLoad(pcLoad),
		.pcTarget(pcTarget),
		.wbStrobe(wbStrobe),
		.halted(halted),
		.running(running)
	);

	regFile #(.BITS(BITS)) regFile_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.rdAddr(rdAddr),
		.rsAddr(rsAddr),
		.useImm(useImm),
		.imm(imm),
		.regWrite(regWrite),
		.wrData(aluOut),
		.opA(opA),
		.opB(opB)
	);

	alu #(.BITS(BITS)) alu_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.A(opA),
		.B(opB),
		.aluOp(aluOp),
		.aluEn(aluEn),
		.aluOut(aluOut),
		.C(C),
		.Z(Z),
		.S(S)
	);

endmodule

// File: src/pcCounter.sv
// program counter for the core, cleared on start, stepped or loaded at the end of each EXEC
module pcCounter (
	input logic CLK,
	input logic RSTb,
	input logic pcClear,
	input logic pcInc,
	input logic pcLoad,
	input cpuPkg::pcT pcTarget,
	output cpuPkg::pcT pc
);
	import cpuPkg::*;

	pcT pcReg;

	assign pc = pcReg;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pcReg <= '0;
		end else if (pcClear) begin
			pcReg <= '0; // restart at address 0
		end else if (pcLoad) begin
			pcReg <= pcTarget; // taken branch
		end else if (pcInc) begin
			pcReg <= pcReg + pcT'(1); // wraps 255 -> 0
		end
	end

	// sequencer picks one way to leave EXEC
	incLoadExclusive: assert property (@(posedge CLK) disable iff (!RSTb)
		!(pcInc && pcLoad));

endmodule

// File: src/progMem.sv
// program store, loaded by the host and read by the core one cycle after the address
module progMem (
	input logic CLK,
	input logic progWrite, // already gated off while running
	input cpuPkg::pcT progAddr,
	input cpuPkg::instrT progData,
	input cpuPkg::pcT pc,
	output cpuPkg::instrT instr
);
	import cpuPkg::*;

	localparam int memDepth = 2 ** $bits(pcT);

	instrT mem [memDepth];

	// host write port
	always_ff @(posedge CLK) begin
		if (progWrite) begin
			mem[progAddr] <= progData;
		end
	end

	// registered fetch, word is valid in EXEC
	always_ff @(posedge CLK) begin
		instr <= mem[pc];
	end

endmodule

// File: src/regFile.sv
// sixteen general registers feeding the ALU, with the immediate byte muxed onto operand B
module regFile #(
	parameter int BITS = cpuPkg::dataWidth
) (
	input logic CLK,
	input logic RSTb,
	input cpuPkg::regAddrT rdAddr,
	input cpuPkg::regAddrT rsAddr,
	input logic useImm,
	input cpuPkg::immT imm,
	input logic regWrite,
	input logic [BITS-1:0] wrData,
	output logic [BITS-1:0] opA,
	output logic [BITS-1:0] opB
);
	import cpuPkg::*;

	localparam int numRegs = 2 ** $bits(regAddrT);

	logic [BITS-1:0] regs [numRegs];

	assign opA = regs[rdAddr]; // rd is also the first source
	assign opB = useImm ? BITS'(imm) : regs[rsAddr];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite) begin
			regs[rdAddr] <= wrData;
		end
	end

endmodule

// File: src/sequencer.sv
// two-cycle fetch/execute FSM that decodes each word and steers the ALU, registers and pc
module sequencer (
	input logic CLK,
	input logic RSTb,
	input logic start,
	input cpuPkg::instrT instr,
	input logic C,
	input logic Z,
	input logic S,
	output cpuPkg::regAddrT rdAddr,
	output cpuPkg::regAddrT rsAddr,
	output logic useImm,
	output cpuPkg::immT imm,
	output cpuPkg::aluOpT aluOp,
	output logic aluEn,
	output logic regWrite,
	output logic pcClear,
	output logic pcInc,
	output logic pcLoad,
	output cpuPkg::pcT pcTarget,
	output logic wbStrobe,
	output logic halted,
	output logic running
);
	import cpuPkg::*;

	seqStateT state, stateNext;
	logic taken;

	// field slices, only acted on in EXEC
	assign rdAddr = getRd(instr);
	assign rsAddr = getRs(instr);
	assign imm = getImm(instr);
	assign pcTarget = pcT'(getImm(instr));

	assign running = (state == FETCH) || (state == EXEC);
	assign halted = (state == HALT);
	assign wbStrobe = regWrite; // one strobe per register write

	// flags still hold the previous instruction's result here
	always_comb begin
		case (getCond(instr))
			brAlways: taken = 1'b1;
			brCarry: taken = C;
			brZero: taken = Z;
			brSign: taken = S;
			brNotZero: taken = !Z;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		stateNext = state;
		useImm = 1'b0;
		aluOp = aluMove;
		aluEn = 1'b0;
		regWrite = 1'b0;
		pcClear = 1'b0;
		pcInc = 1'b0;
		pcLoad = 1'b0;
		case (state)
			IDLE, HALT: begin
				if (start) begin
					pcClear = 1'b1;
					stateNext = FETCH;
				end
			end
			FETCH: stateNext = EXEC;
			EXEC: begin
				stateNext = FETCH;
				pcInc = 1'b1;
				case (getMajor(instr))
					majAlu: begin
						aluOp = getAluOp(instr);
						aluEn = 1'b1;
						regWrite = !(getAluOp(instr) inside {[aluClrC:aluSetS]}); // flag ops
					end
					majLdi: begin
						useImm = 1'b1; // move of the zero-extended byte
						aluEn = 1'b1;
						regWrite = 1'b1;
					end
					majBranch: begin
						if (taken) begin
							pcLoad = 1'b1;
							pcInc = 1'b0;
						end
					end
					majHalt: stateNext = HALT;
					default: ; // unused opcodes fall through
				endcase
			end
			default: stateNext = IDLE;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= IDLE;
		end else begin
			state <= stateNext;
		end
	end

	// an unloaded program word would steer the datapath with X
	instrKnownInExec: assert property (@(posedge CLK) disable iff (!RSTb)
		state == EXEC |-> !$isunknown(instr));

endmodule

// File: tb.f
common/cpuPkg.sv
alu/alu.sv
src/progMem.sv
src/pcCounter.sv
src/sequencer.sv
src/regFile.sv
src/cpuTop.sv
bench/cpuTb.sv
